/* Bender.yml */
package:
  name: rvseed_pipe

sources:
  - logic/rvseed_isa_pkg.sv
  - logic/rvseed_pipe_pkg.sv
  - logic/id_hazard.sv
  - logic/reg_file.sv
  - logic/ex_alu.sv
  - logic/data_mem.sv
  - logic/rvseed_pipe.sv
  - target: test
    files:
      - tests/rvseed_pipe_sva.sv
      - tests/rvseed_pipe_tb.sv

/* logic/data_mem.sv */
`timescale 1ns/1ps

module data_mem (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    we,
    input  logic [rvseed_pipe_pkg::dmem_addr_w-1:0] addr,
    input  logic [rvseed_isa_pkg::xlen-1:0]         wdata,
    output logic [rvseed_isa_pkg::xlen-1:0]         rdata
);

    import rvseed_isa_pkg::*;
    import rvseed_pipe_pkg::*;

    logic [xlen-1:0] mem [dmem_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                mem[i] <= '0;  // Untouched words load as zero.
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];  // Load result available in MEM.

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  rvseed_isa_pkg::opcode_e             op,
    input  logic [rvseed_isa_pkg::xlen-1:0]     rf_a,
    input  logic [rvseed_isa_pkg::xlen-1:0]     rf_b,
    input  logic [rvseed_isa_pkg::xlen-1:0]     imm,
    input  logic [rvseed_isa_pkg::xlen-1:0]     exmem_val,
    input  logic [rvseed_isa_pkg::xlen-1:0]     memwb_val,
    input  rvseed_pipe_pkg::fwd_sel_e           fwd_a,
    input  rvseed_pipe_pkg::fwd_sel_e           fwd_b,
    output logic [rvseed_isa_pkg::xlen-1:0]     alu_res,
    output logic [rvseed_isa_pkg::xlen-1:0]     store_data
);

    import rvseed_isa_pkg::*;
    import rvseed_pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] rf_val,
        input logic [xlen-1:0] exmem,
        input logic [xlen-1:0] memwb
    );
        case (sel)
            FWD_EXMEM: return exmem;
            FWD_MEMWB: return memwb;
            default:   return rf_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, rf_a, exmem_val, memwb_val);
    assign op_b = fwd_mux(fwd_b, rf_b, exmem_val, memwb_val);

    always_comb begin
        case (op)
            OP_ADD:  alu_res = op_a + op_b;
            OP_SUB:  alu_res = op_a - op_b;
            OP_AND:  alu_res = op_a & op_b;
            OP_OR:   alu_res = op_a | op_b;
            OP_XOR:  alu_res = op_a ^ op_b;
            default: alu_res = op_a + imm;  // ADDI, and byte address for LD/SD.
        endcase
    end

    assign store_data = op_b;

endmodule

/* logic/id_hazard.sv */
`timescale 1ns/1ps

module id_hazard (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        id_valid,
    input  rvseed_isa_pkg::opcode_e     id_op,
    input  rvseed_isa_pkg::reg_addr_t   id_rs1,
    input  rvseed_isa_pkg::reg_addr_t   id_rs2,
    input  logic                        ex_valid,
    input  logic                        ex_is_load,
    input  rvseed_isa_pkg::reg_addr_t   ex_rd,
    input  logic                        mem_valid,
    input  logic                        mem_wr,
    input  rvseed_isa_pkg::reg_addr_t   mem_rd,
    output logic                        stall,
    output rvseed_pipe_pkg::fwd_sel_e   fwd_a,
    output rvseed_pipe_pkg::fwd_sel_e   fwd_b
);

    import rvseed_isa_pkg::*;
    import rvseed_pipe_pkg::*;

    logic stall_q;
    logic uses_rs2;
    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;
    logic load_use;

    // Younger producer wins.
    function automatic fwd_sel_e pick_fwd(input logic ex_hit, input logic mem_hit);
        if (ex_hit) begin
            return FWD_EXMEM;
        end else if (mem_hit) begin
            return FWD_MEMWB;
        end
        return FWD_RF;
    endfunction

    assign uses_rs2 = (id_op != OP_ADDI) && (id_op != OP_LD);

    // A load in EX has no data yet, so it is never a forwarding source.
    assign ex_hit_a = ex_valid && !ex_is_load && (ex_rd != '0) && (ex_rd == id_rs1);
    assign ex_hit_b = ex_valid && !ex_is_load && (ex_rd != '0) && (ex_rd == id_rs2);

    assign mem_hit_a = mem_valid && mem_wr && (mem_rd != '0) && (mem_rd == id_rs1);
    assign mem_hit_b = mem_valid && mem_wr && (mem_rd != '0) && (mem_rd == id_rs2);

    assign load_use = ex_valid && ex_is_load && (ex_rd != '0) &&
                      ((ex_rd == id_rs1) || (uses_rs2 && (ex_rd == id_rs2)));

    assign stall = id_valid && load_use && !stall_q;  // At most one bubble in a row.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall;
        end
    end

    assign fwd_a = pick_fwd(ex_hit_a, mem_hit_a);
    assign fwd_b = pick_fwd(ex_hit_b, mem_hit_b);

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  rvseed_isa_pkg::reg_addr_t           raddr_a,
    input  rvseed_isa_pkg::reg_addr_t           raddr_b,
    input  logic                                we,
    input  rvseed_isa_pkg::reg_addr_t           waddr,
    input  logic [rvseed_isa_pkg::xlen-1:0]     wdata,
    output logic [rvseed_isa_pkg::xlen-1:0]     rdata_a,
    output logic [rvseed_isa_pkg::xlen-1:0]     rdata_b
);

    import rvseed_isa_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 never written.
            regs[waddr] <= wdata;
        end
    end

    // Write data goes straight through when WB hits the register read in ID.
    assign rdata_a = (raddr_a == '0)                 ? '0    :
                     (we && (raddr_a == waddr))      ? wdata :
                                                       regs[raddr_a];

    assign rdata_b = (raddr_b == '0)                 ? '0    :
                     (we && (raddr_b == waddr))      ? wdata :
                                                       regs[raddr_b];

endmodule

/* logic/rvseed_isa_pkg.sv */
package rvseed_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Architectural widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned xlen       = 64;  // Integer datapath width.
    localparam int unsigned reg_addr_w = 5;   // 32 integer registers.

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pre-decoded opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,  // rd = rs1 + rs2.
        OP_SUB  = 3'd1,  // rd = rs1 - rs2.
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5,  // rd = rs1 + imm.
        OP_LD   = 3'd6,  // rd = mem[rs1 + imm].
        OP_SD   = 3'd7   // mem[rs1 + imm] = rs2.
    } opcode_e;

endpackage

/* logic/rvseed_pipe.sv */
`timescale 1ns/1ps

module rvseed_pipe (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  rvseed_isa_pkg::opcode_e             in_op,
    input  rvseed_isa_pkg::reg_addr_t           in_rs1,
    input  rvseed_isa_pkg::reg_addr_t           in_rs2,
    input  rvseed_isa_pkg::reg_addr_t           in_rd,
    input  logic [rvseed_isa_pkg::xlen-1:0]     in_imm,
    output logic                                in_ready,
    output logic                                retire_valid,
    output logic                                retire_we,
    output rvseed_isa_pkg::reg_addr_t           retire_rd,
    output logic [rvseed_isa_pkg::xlen-1:0]     retire_data
);

    import rvseed_isa_pkg::*;
    import rvseed_pipe_pkg::*;

    // ID stage.
    logic            id_valid;
    opcode_e         id_op;
    reg_addr_t       id_rs1;
    reg_addr_t       id_rs2;
    reg_addr_t       id_rd;
    logic [xlen-1:0] id_imm;

    // ID/EX.
    logic            idex_valid;
    logic            idex_wr;
    opcode_e         idex_op;
    reg_addr_t       idex_rd;
    logic [xlen-1:0] idex_a;
    logic [xlen-1:0] idex_b;
    logic [xlen-1:0] idex_imm;
    fwd_sel_e        idex_fwd_a;
    fwd_sel_e        idex_fwd_b;

    // EX/MEM.
    logic            exmem_valid;
    logic            exmem_wr;
    logic            exmem_load;
    logic            exmem_store;
    reg_addr_t       exmem_rd;
    logic [xlen-1:0] exmem_alu;
    logic [xlen-1:0] exmem_sdata;

    // MEM/WB.
    logic            memwb_valid;
    logic            memwb_wr;
    reg_addr_t       memwb_rd;
    logic [xlen-1:0] memwb_data;

    logic            in_fire;
    logic            stall;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    reg_addr_t       ex_dst;
    logic [xlen-1:0] rf_a;
    logic [xlen-1:0] rf_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] load_data;

    assign in_ready = !stall;
    assign in_fire  = in_valid && in_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ID
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (!stall) begin  // Holds its instruction during a stall.
            id_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            id_op  <= in_op;
            id_rs1 <= in_rs1;
            id_rs2 <= in_rs2;
            id_rd  <= in_rd;
            id_imm <= in_imm;
        end
    end

    // Stores never look like producers to the hazard unit.
    assign ex_dst = idex_wr ? idex_rd : '0;

    id_hazard u_id_hazard (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .id_op      (id_op),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .ex_valid   (idex_valid),
        .ex_is_load (idex_op == OP_LD),
        .ex_rd      (ex_dst),
        .mem_valid  (exmem_valid),
        .mem_wr     (exmem_wr),
        .mem_rd     (exmem_rd),
        .stall      (stall),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (id_rs1),
        .raddr_b (id_rs2),
        .we      (retire_we),
        .waddr   (memwb_rd),
        .wdata   (memwb_data),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid <= 1'b0;
        end else begin
            idex_valid <= id_valid && !stall;  // Bubble on a load-use stall.
        end
    end

    always_ff @(posedge clk) begin
        idex_op    <= id_op;
        idex_rd    <= id_rd;
        idex_wr    <= (id_op != OP_SD) && (id_rd != '0);
        idex_a     <= rf_a;
        idex_b     <= rf_b;
        idex_imm   <= id_imm;
        idex_fwd_a <= fwd_a;
        idex_fwd_b <= fwd_b;
    end

    ex_alu u_ex_alu (
        .op         (idex_op),
        .rf_a       (idex_a),
        .rf_b       (idex_b),
        .imm        (idex_imm),
        .exmem_val  (exmem_alu),
        .memwb_val  (memwb_data),
        .fwd_a      (idex_fwd_a),
        .fwd_b      (idex_fwd_b),
        .alu_res    (alu_res),
        .store_data (store_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM and WB
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
        end else begin
            exmem_valid <= idex_valid;
            memwb_valid <= exmem_valid;
        end
    end

    always_ff @(posedge clk) begin
        exmem_wr    <= idex_wr;
        exmem_rd    <= idex_rd;
        exmem_load  <= (idex_op == OP_LD);
        exmem_store <= (idex_op == OP_SD);
        exmem_alu   <= alu_res;
        exmem_sdata <= store_data;
    end

    data_mem u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (exmem_valid && exmem_store),
        .addr  (exmem_alu[dmem_lsb +: dmem_addr_w]),
        .wdata (exmem_sdata),
        .rdata (load_data)
    );

    always_ff @(posedge clk) begin
        memwb_wr   <= exmem_wr;
        memwb_rd   <= exmem_rd;
        memwb_data <= exmem_load ? load_data : exmem_alu;
    end

    assign retire_valid = memwb_valid;
    assign retire_we    = memwb_valid && memwb_wr;  // Low for stores and x0.
    assign retire_rd    = memwb_rd;
    assign retire_data  = memwb_data;

endmodule

/* logic/rvseed_pipe_pkg.sv */
package rvseed_pipe_pkg;

    // Operand source chosen in ID, used in EX.
    typedef enum logic [1:0] {
        FWD_RF    = 2'd0,  // Value read from the register file.
        FWD_EXMEM = 2'd1,  // ALU result of the instruction one ahead.
        FWD_MEMWB = 2'd2   // Result of the instruction two ahead.
    } fwd_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scratch data memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned dmem_depth  = 64;  // Doublewords.
    localparam int unsigned dmem_addr_w = 6;   // Doubleword index width.
    localparam int unsigned dmem_lsb    = 3;   // Byte offset bits dropped.

endpackage

/* rvseed_pipe.f */
logic/rvseed_isa_pkg.sv
logic/rvseed_pipe_pkg.sv
logic/id_hazard.sv
logic/reg_file.sv
logic/ex_alu.sv
logic/data_mem.sv
logic/rvseed_pipe.sv
tests/rvseed_pipe_sva.sv
tests/rvseed_pipe_tb.sv

/* tests/rvseed_pipe_sva.sv */
`timescale 1ns/1ps

module rvseed_pipe_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid,
    input logic                      in_ready,
    input logic                      retire_valid,
    input logic                      retire_we,
    input rvseed_isa_pkg::reg_addr_t retire_rd
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset and handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> !retire_valid [*4];  // Pipe is empty.
    endproperty

    property single_stall;
        @(posedge clk) disable iff (!rst_n) !in_ready |=> in_ready;
    endproperty

    property no_x0_write;
        @(posedge clk) disable iff (!rst_n) retire_we |-> (retire_rd != '0);
    endproperty

    // Two idle input cycles leave ID empty, so nothing can stall.
    property ready_when_idle;
        @(posedge clk) disable iff (!rst_n) (!in_valid ##1 !in_valid) |=> in_ready;
    endproperty

    a_quiet_after_reset : assert property (quiet_after_reset)
        else $error("retire_valid high during the first 4 cycles after reset");
    a_single_stall : assert property (single_stall)
        else $error("in_ready low in two consecutive cycles");
    a_no_x0_write : assert property (no_x0_write)
        else $error("retire_we high with retire_rd zero");
    a_ready_when_idle : assert property (ready_when_idle)
        else $error("in_ready low after two idle input cycles");

endmodule

/* tests/rvseed_pipe_tb.sv */
`timescale 1ns/1ps

module rvseed_pipe_tb;

    import rvseed_isa_pkg::*;
    import rvseed_pipe_pkg::*;

    localparam int unsigned issued_ops  = 342;  // Directed plus random ops.
    localparam int unsigned cycle_limit = 2 * issued_ops + 100;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    opcode_e         in_op;
    reg_addr_t       in_rs1;
    reg_addr_t       in_rs2;
    reg_addr_t       in_rd;
    logic [xlen-1:0] in_imm;
    logic            in_ready;
    logic            retire_valid;
    logic            retire_we;
    reg_addr_t       retire_rd;
    logic [xlen-1:0] retire_data;

    logic [xlen-1:0] model_regs [2**reg_addr_w];
    logic [xlen-1:0] model_mem [dmem_depth];
    reg_addr_t       exp_rd_q [$];
    logic            exp_we_q [$];
    logic [xlen-1:0] exp_data_q [$];
    int              exp_cyc_q [$];

    int        cyc;
    int        pass_cnt;
    int        fail_cnt;
    int        fail_base;
    int        stall_seen;
    int        stall_exp;
    int        last_acc;
    opcode_e   last_op;
    reg_addr_t last_rd;
    logic      last_stalled;

    rvseed_pipe u_rvseed_pipe (.*);

    bind rvseed_pipe rvseed_pipe_sva u_sva (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > cycle_limit) begin
            $display("pipeline hung, run stopped after %0d cycles", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic reads_rs2(input opcode_e op);
        return (op != OP_ADDI) && (op != OP_LD);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_retire();
        reg_addr_t       e_rd;
        logic            e_we;
        logic [xlen-1:0] e_data;
        int              e_cyc;
        if (exp_rd_q.size() == 0) begin
            fail_cnt++;
            $display("retire seen with no instruction outstanding");
            return;
        end
        e_rd   = exp_rd_q.pop_front();
        e_we   = exp_we_q.pop_front();
        e_data = exp_data_q.pop_front();
        e_cyc  = exp_cyc_q.pop_front();
        assert (retire_rd == e_rd) pass_cnt++;
        else begin
            fail_cnt++;
            $display("error retire_rd: got %h expected %h", retire_rd, e_rd);
        end
        assert (retire_we == e_we) pass_cnt++;
        else begin
            fail_cnt++;
            $display("error retire_we: got %h expected %h", retire_we, e_we);
        end
        assert (!e_we || retire_data == e_data) pass_cnt++;  // Data only matters on a write.
        else begin
            fail_cnt++;
            $display("error retire_data: got %h expected %h", retire_data, e_data);
        end
        assert (cyc == e_cyc) pass_cnt++;
        else begin
            fail_cnt++;
            $display("error retire cycle: got %h expected %h", cyc, e_cyc);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (!in_ready) begin
                stall_seen++;
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer.
    task automatic send(input opcode_e op, input reg_addr_t rs1, input reg_addr_t rs2,
                        input reg_addr_t rd, input logic [xlen-1:0] imm);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] res;
        logic            we;
        logic            dep;
        logic            stalls;
        int              acc;
        dep = (last_rd != '0) && ((rs1 == last_rd) || (reads_rs2(op) && rs2 == last_rd));
        in_valid = 1'b1;
        in_op    = op;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_rd    = rd;
        in_imm   = imm;
        while (!in_ready) @(negedge clk);
        acc    = cyc;
        // Load still in EX while this op sits in ID.
        stalls = (acc == last_acc + 1 + int'(last_stalled)) && (last_op == OP_LD) && dep;
        a      = model_regs[rs1];
        b      = model_regs[rs2];
        addr   = a + imm;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_LD:   res = model_mem[addr[8:3]];
            default: res = addr;
        endcase
        if (op == OP_SD) begin
            model_mem[addr[8:3]] = b;
        end
        we = (op != OP_SD) && (rd != '0);
        if (we) begin
            model_regs[rd] = res;
        end
        exp_rd_q.push_back(rd);
        exp_we_q.push_back(we);
        exp_data_q.push_back(res);
        exp_cyc_q.push_back(acc + 4 + int'(stalls));
        if (stalls) begin
            stall_exp++;
        end
        last_acc     = acc;
        last_op      = op;
        last_rd      = (op == OP_SD) ? '0 : rd;
        last_stalled = stalls;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        in_valid = 1'b0;
        while (exp_rd_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        assert (stall_seen == stall_exp) pass_cnt++;
        else begin
            fail_cnt++;
            $display("error stall count: got %h expected %h", stall_seen, stall_exp);
        end
        $display("%-10s finished, %0d failed checks", name, fail_cnt - fail_base);
        fail_base = fail_cnt;
    endtask

    initial begin
        void'($urandom(22146));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_op = OP_ADD;
        in_rs1 = '0;
        in_rs2 = '0;
        in_rd = '0;
        in_imm = '0;
        cyc = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        fail_base = 0;
        stall_seen = 0;
        stall_exp = 0;
        last_acc = -10;
        last_op = OP_ADD;
        last_rd = '0;
        last_stalled = 1'b0;
        for (int i = 0; i < 2**reg_addr_w; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        send(OP_ADDI, 0, 0, 1, 64'h0123_4567_89ab_cdef);
        send(OP_ADDI, 0, 0, 2, 64'h1111_2222_3333_4444);
        send(OP_ADDI, 0, 0, 3, 64'hf0f0_f0f0_0f0f_0f0f);
        send(OP_ADDI, 0, 0, 4, 64'h00ff_00ff_ff00_ff00);
        idle(3);
        send(OP_ADD, 1, 2, 10, '0);
        send(OP_SUB, 2, 1, 11, '0);
        send(OP_AND, 3, 4, 12, '0);
        send(OP_OR, 3, 4, 13, '0);
        send(OP_XOR, 1, 3, 14, '0);
        send(OP_ADDI, 4, 0, 15, 64'hffff_ffff_ffff_fff0);
        end_test("alu");

        for (int d = 1; d <= 3; d++) begin
            send(OP_ADDI, 0, 0, 5, 64'(d * 7));
            idle(d - 1);
            send(OP_ADD, 5, 1, 5, '0);  // Distance d to its producer.
            idle(d - 1);
            send(OP_SUB, 2, 5, 5, '0);
            idle(d - 1);
            send(OP_XOR, 5, 3, 6, '0);
            idle(3);
        end
        end_test("forward");

        send(OP_SD, 0, 1, 0, 64'h80);
        idle(2);
        send(OP_LD, 0, 0, 7, 64'h80);
        send(OP_ADD, 7, 2, 8, '0);  // Load-use, one bubble.
        send(OP_LD, 0, 0, 9, 64'h80);
        send(OP_XOR, 1, 2, 10, '0);  // Independent, no bubble.
        send(OP_SUB, 9, 8, 11, '0);
        end_test("load_use");

        for (int i = 0; i < 4; i++) begin
            send(OP_SD, 0, reg_addr_t'(i + 1), 0, 64'(i * 16));
        end
        for (int i = 0; i < 4; i++) begin
            send(OP_LD, 0, 0, reg_addr_t'(i + 16), 64'(i * 16));
        end
        send(OP_LD, 0, 0, 20, 64'h1f0);  // Never stored.
        send(OP_LD, 0, 0, 21, 64'h8);
        end_test("mem");

        send(OP_ADDI, 0, 0, 0, 64'hdead);
        send(OP_ADD, 1, 2, 0, '0);
        send(OP_OR, 0, 1, 12, '0);  // Writer of x0 still in EX.
        send(OP_ADD, 0, 0, 13, '0);
        end_test("x0");

        for (int n = 0; n < 300; n++) begin
            opcode_e         op;
            reg_addr_t       rs1;
            logic [xlen-1:0] imm;
            if ($urandom_range(0, 3) == 0) begin
                idle($urandom_range(1, 2));
            end
            op  = opcode_e'($urandom_range(0, 7));
            rs1 = reg_addr_t'($urandom_range(0, 7));
            imm = {$urandom, $urandom};
            if (op == OP_LD || op == OP_SD) begin
                imm = 64'($urandom_range(0, dmem_depth - 1) * 8);
                if ($urandom_range(0, 1) == 0) begin
                    rs1 = '0;  // Absolute address, more hits.
                end
            end
            send(op, rs1, reg_addr_t'($urandom_range(0, 7)),
                 reg_addr_t'($urandom_range(0, 7)), imm);
        end
        end_test("random");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
